/* common/decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [19:0] imm20_t;
    typedef logic [4:0]  micop_t;
    typedef logic [2:0]  exec_unit_t;
    typedef logic [1:0]  disp_que_t;
    typedef logic [2:0]  issue_que_t;
    typedef logic [2:0]  imm_fmt_t;

    localparam exec_unit_t UNIT_NONE = 3'd0;
    localparam exec_unit_t UNIT_ALU  = 3'd1;
    localparam exec_unit_t UNIT_BRU  = 3'd2;
    localparam exec_unit_t UNIT_LDU  = 3'd3;
    localparam exec_unit_t UNIT_STU  = 3'd4;
    localparam exec_unit_t UNIT_MDU  = 3'd5;
    localparam exec_unit_t UNIT_SCU  = 3'd6;

    localparam disp_que_t INT_BLOCK     = 2'd0;
    localparam disp_que_t MEM_BLOCK     = 2'd1;
    localparam disp_que_t UNKNOWN_BLOCK = 2'd2;

    // issue queue ids follow the unit codes
    localparam issue_que_t NONE_IQ = 3'd0;
    localparam issue_que_t ALU_IQ  = 3'd1;
    localparam issue_que_t BRU_IQ  = 3'd2;
    localparam issue_que_t LDU_IQ  = 3'd3;
    localparam issue_que_t STU_IQ  = 3'd4;
    localparam issue_que_t MDU_IQ  = 3'd5;
    localparam issue_que_t SCU_IQ  = 3'd6;

    localparam imm_fmt_t FMT_NONE  = 3'd0;
    localparam imm_fmt_t FMT_I     = 3'd1;
    localparam imm_fmt_t FMT_S     = 3'd2;
    localparam imm_fmt_t FMT_B     = 3'd3;
    localparam imm_fmt_t FMT_U     = 3'd4;
    localparam imm_fmt_t FMT_J     = 3'd5;
    localparam imm_fmt_t FMT_CSR   = 3'd6;
    localparam imm_fmt_t FMT_SHIFT = 3'd7;

    localparam micop_t MICOP_NONE = 5'd0;

    // immediate forms share the register form's code
    localparam micop_t ALU_LUI  = 5'd1;
    localparam micop_t ALU_ADD  = 5'd2;
    localparam micop_t ALU_SUB  = 5'd3;
    localparam micop_t ALU_ADDW = 5'd4;
    localparam micop_t ALU_SUBW = 5'd5;
    localparam micop_t ALU_SLL  = 5'd6;
    localparam micop_t ALU_SRL  = 5'd7;
    localparam micop_t ALU_SRA  = 5'd8;
    localparam micop_t ALU_SLLW = 5'd9;
    localparam micop_t ALU_SRLW = 5'd10;
    localparam micop_t ALU_SRAW = 5'd11;
    localparam micop_t ALU_XOR  = 5'd12;
    localparam micop_t ALU_OR   = 5'd13;
    localparam micop_t ALU_AND  = 5'd14;
    localparam micop_t ALU_SLT  = 5'd15;
    localparam micop_t ALU_SLTU = 5'd16;

    localparam micop_t BRU_AUIPC = 5'd1;
    localparam micop_t BRU_JAL   = 5'd2;
    localparam micop_t BRU_JALR  = 5'd3;
    localparam micop_t BRU_BEQ   = 5'd4;
    localparam micop_t BRU_BNE   = 5'd5;
    localparam micop_t BRU_BLT   = 5'd6;
    localparam micop_t BRU_BGE   = 5'd7;
    localparam micop_t BRU_BLTU  = 5'd8;
    localparam micop_t BRU_BGEU  = 5'd9;

    localparam micop_t LDU_LB  = 5'd1;
    localparam micop_t LDU_LBU = 5'd2;
    localparam micop_t LDU_LH  = 5'd3;
    localparam micop_t LDU_LHU = 5'd4;
    localparam micop_t LDU_LW  = 5'd5;
    localparam micop_t LDU_LWU = 5'd6;
    localparam micop_t LDU_LD  = 5'd7;

    localparam micop_t STU_SB = 5'd1;
    localparam micop_t STU_SH = 5'd2;
    localparam micop_t STU_SW = 5'd3;
    localparam micop_t STU_SD = 5'd4;

    localparam micop_t MDU_MUL    = 5'd1;
    localparam micop_t MDU_MULW   = 5'd2;
    localparam micop_t MDU_MULH   = 5'd3;
    localparam micop_t MDU_MULHU  = 5'd4;
    localparam micop_t MDU_MULHSU = 5'd5;
    localparam micop_t MDU_DIV    = 5'd6;
    localparam micop_t MDU_DIVW   = 5'd7;
    localparam micop_t MDU_DIVU   = 5'd8;
    localparam micop_t MDU_REM    = 5'd9;
    localparam micop_t MDU_REMW   = 5'd10;
    localparam micop_t MDU_REMU   = 5'd11;
    localparam micop_t MDU_REMUW  = 5'd12;
    localparam micop_t MDU_DIVUW  = 5'd13;

    localparam micop_t SCU_MRET   = 5'd1;
    localparam micop_t SCU_ECALL  = 5'd2;
    localparam micop_t SCU_EBREAK = 5'd3;
    localparam micop_t SCU_CSRRW  = 5'd4;
    localparam micop_t SCU_CSRRC  = 5'd5;
    localparam micop_t SCU_CSRRS  = 5'd6;
    localparam micop_t SCU_CSRRWI = 5'd7;
    localparam micop_t SCU_CSRRCI = 5'd8;
    localparam micop_t SCU_CSRRSI = 5'd9;

    typedef struct packed {
        exec_unit_t unit;
        micop_t     micop;
        imm_fmt_t   imm_fmt;
        logic       reads_rs1;
        logic       reads_rs2;
        logic       writes_rd;
        logic       is_imm_math;
        logic       is_mv_candidate;
        logic       is_int_math;
        logic       unknown;
    } match_t;

    typedef struct packed {
        micop_t     micop;
        exec_unit_t unit;
        imm20_t     imm20;
        reg_idx_t   rd_idx;
        reg_idx_t   rs1_idx;
        reg_idx_t   rs2_idx;
        logic       rd_wen;
        logic       use_imm;
        logic       is_mv;
        logic       need_serialize;
        logic       is_store;
        disp_que_t  disp_que;
        issue_que_t issue_que;
    } dec_info_t;

endpackage

/* decoder/decinfo_reg.sv */
`timescale 1ns/100ps

module decinfo_reg
    import decode_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_valid,
    input  dec_info_t i_info,
    input  logic      i_unknown,
    output logic      o_valid,
    output dec_info_t o_decinfo,
    output logic      o_unknown_inst
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_unknown_inst <= 1'b0;
        end else begin
            o_valid <= i_valid;
            // flag only meaningful alongside valid
            o_unknown_inst <= i_valid && i_unknown;
        end
    end

    // record holds between strobes
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_decinfo <= i_info;
        end
    end

    // unknown flag only with a valid record routed to the unknown block
    a_unknown_needs_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_unknown_inst |-> (o_valid && (o_decinfo.disp_que == UNKNOWN_BLOCK)));

endmodule

/* decoder/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen
    import decode_pkg::*;
(
    input  inst_t    i_inst,
    input  imm_fmt_t i_fmt,
    output imm20_t   o_imm
);

    always_comb begin
        case (i_fmt)
            FMT_I: o_imm = {{8{i_inst[31]}}, i_inst[31:20]};
            FMT_S: o_imm = {{8{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            FMT_B: o_imm = {{8{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
            // upper bits as is, shifted later by the unit
            FMT_U: o_imm = i_inst[31:12];
            // jump offset bits 19:1, sign bit dropped
            FMT_J: o_imm = {i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
            // csr number then zimm
            FMT_CSR: o_imm = {3'd0, i_inst[31:20], i_inst[19:15]};
            FMT_SHIFT: o_imm = {14'd0, i_inst[25:20]};
            default: o_imm = '0;
        endcase
    end

endmodule

/* decoder/inst_matcher.sv */
`timescale 1ns/100ps

module inst_matcher
    import decode_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_valid,
    input  inst_t  i_inst,
    output logic   o_valid,
    output inst_t  o_inst,
    output match_t o_match
);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [5:0] f6;
    match_t     m;

    assign opcode = i_inst[6:0];
    assign f3 = i_inst[14:12];
    assign f7 = i_inst[31:25];
    assign f6 = i_inst[31:26];

    // regs packs {rs1, rs2, rd}
    function automatic match_t base_match(exec_unit_t unit, imm_fmt_t fmt, logic [2:0] regs);
        match_t b;
        b = '0;
        b.unit = unit;
        b.imm_fmt = fmt;
        {b.reads_rs1, b.reads_rs2, b.writes_rd} = regs;
        return b;
    endfunction

    always_comb begin
        m = '0;
        case (opcode)
            7'b0110111: begin
                m = base_match(UNIT_ALU, FMT_U, 3'b001);
                m.micop = ALU_LUI;
            end
            7'b0010111: begin
                m = base_match(UNIT_BRU, FMT_U, 3'b001);
                m.micop = BRU_AUIPC;
            end
            7'b1101111: begin
                m = base_match(UNIT_BRU, FMT_J, 3'b001);
                m.micop = BRU_JAL;
            end
            7'b1100111: begin
                m = base_match(UNIT_BRU, FMT_I, 3'b101);
                m.micop = (f3 == 3'b000) ? BRU_JALR : MICOP_NONE;
            end
            7'b1100011: begin
                m = base_match(UNIT_BRU, FMT_B, 3'b110);
                case (f3)
                    3'b000: m.micop = BRU_BEQ;
                    3'b001: m.micop = BRU_BNE;
                    3'b100: m.micop = BRU_BLT;
                    3'b101: m.micop = BRU_BGE;
                    3'b110: m.micop = BRU_BLTU;
                    3'b111: m.micop = BRU_BGEU;
                    default: m.micop = MICOP_NONE;
                endcase
            end
            7'b0000011: begin
                m = base_match(UNIT_LDU, FMT_I, 3'b101);
                case (f3)
                    3'b000: m.micop = LDU_LB;
                    3'b100: m.micop = LDU_LBU;
                    3'b001: m.micop = LDU_LH;
                    3'b101: m.micop = LDU_LHU;
                    3'b010: m.micop = LDU_LW;
                    3'b110: m.micop = LDU_LWU;
                    3'b011: m.micop = LDU_LD;
                    default: m.micop = MICOP_NONE;
                endcase
            end
            7'b0100011: begin
                m = base_match(UNIT_STU, FMT_S, 3'b110);
                case (f3)
                    3'b000: m.micop = STU_SB;
                    3'b001: m.micop = STU_SH;
                    3'b010: m.micop = STU_SW;
                    3'b011: m.micop = STU_SD;
                    default: m.micop = MICOP_NONE;
                endcase
            end
            7'b0010011: begin
                m = base_match(UNIT_ALU, (f3[1:0] == 2'b01) ? FMT_SHIFT : FMT_I, 3'b101);
                m.is_imm_math = 1'b1;
                m.is_mv_candidate = (f3 == 3'b000);
                case (f3)
                    3'b000: m.micop = ALU_ADD;
                    3'b001: m.micop = (f6 == 6'b000000) ? ALU_SLL : MICOP_NONE;
                    3'b010: m.micop = ALU_SLT;
                    3'b011: m.micop = ALU_SLTU;
                    3'b100: m.micop = ALU_XOR;
                    // rv64 shifts carry a 6-bit amount
                    3'b101: m.micop = (f6 == 6'b000000) ? ALU_SRL :
                                      (f6 == 6'b010000) ? ALU_SRA : MICOP_NONE;
                    3'b110: m.micop = ALU_OR;
                    default: m.micop = ALU_AND;
                endcase
            end
            7'b0011011: begin
                m = base_match(UNIT_ALU, (f3[1:0] == 2'b01) ? FMT_SHIFT : FMT_I, 3'b101);
                m.is_imm_math = 1'b1;
                case ({f7, f3})
                    10'b0000000_001: m.micop = ALU_SLLW;
                    10'b0000000_101: m.micop = ALU_SRLW;
                    10'b0100000_101: m.micop = ALU_SRAW;
                    default: m.micop = (f3 == 3'b000) ? ALU_ADDW : MICOP_NONE;
                endcase
            end
            7'b0110011: begin
                m = base_match((f7 == 7'b0000001) ? UNIT_MDU : UNIT_ALU, FMT_NONE, 3'b111);
                m.is_int_math = (f7 != 7'b0000001);
                m.is_mv_candidate = ({f7, f3} == 10'b0000000_000);
                case ({f7, f3})
                    10'b0000000_000: m.micop = ALU_ADD;
                    10'b0000000_001: m.micop = ALU_SLL;
                    10'b0000000_010: m.micop = ALU_SLT;
                    10'b0000000_011: m.micop = ALU_SLTU;
                    10'b0000000_100: m.micop = ALU_XOR;
                    10'b0000000_101: m.micop = ALU_SRL;
                    10'b0000000_110: m.micop = ALU_OR;
                    10'b0000000_111: m.micop = ALU_AND;
                    10'b0100000_000: m.micop = ALU_SUB;
                    10'b0100000_101: m.micop = ALU_SRA;
                    10'b0000001_000: m.micop = MDU_MUL;
                    10'b0000001_001: m.micop = MDU_MULH;
                    10'b0000001_010: m.micop = MDU_MULHSU;
                    10'b0000001_011: m.micop = MDU_MULHU;
                    10'b0000001_100: m.micop = MDU_DIV;
                    10'b0000001_101: m.micop = MDU_DIVU;
                    10'b0000001_110: m.micop = MDU_REM;
                    10'b0000001_111: m.micop = MDU_REMU;
                    default: m.micop = MICOP_NONE;
                endcase
            end
            7'b0111011: begin
                m = base_match((f7 == 7'b0000001) ? UNIT_MDU : UNIT_ALU, FMT_NONE, 3'b111);
                m.is_int_math = (f7 != 7'b0000001);
                case ({f7, f3})
                    10'b0000000_000: m.micop = ALU_ADDW;
                    10'b0000000_001: m.micop = ALU_SLLW;
                    10'b0000000_101: m.micop = ALU_SRLW;
                    10'b0100000_000: m.micop = ALU_SUBW;
                    10'b0100000_101: m.micop = ALU_SRAW;
                    10'b0000001_000: m.micop = MDU_MULW;
                    10'b0000001_100: m.micop = MDU_DIVW;
                    10'b0000001_101: m.micop = MDU_DIVUW;
                    10'b0000001_110: m.micop = MDU_REMW;
                    10'b0000001_111: m.micop = MDU_REMUW;
                    default: m.micop = MICOP_NONE;
                endcase
            end
            7'b1110011: begin
                if (f3 == 3'b000) begin
                    m = base_match(UNIT_SCU, FMT_NONE, 3'b000);
                    case (i_inst)
                        32'h0000_0073: m.micop = SCU_ECALL;
                        32'h0010_0073: m.micop = SCU_EBREAK;
                        32'h3020_0073: m.micop = SCU_MRET;
                        default: m.micop = MICOP_NONE;
                    endcase
                end else begin
                    // immediate csr forms hold zimm where rs1 would be
                    m = base_match(UNIT_SCU, FMT_CSR, {~f3[2], 2'b01});
                    case (f3)
                        3'b001: m.micop = SCU_CSRRW;
                        3'b010: m.micop = SCU_CSRRS;
                        3'b011: m.micop = SCU_CSRRC;
                        3'b101: m.micop = SCU_CSRRWI;
                        3'b110: m.micop = SCU_CSRRSI;
                        3'b111: m.micop = SCU_CSRRCI;
                        default: m.micop = MICOP_NONE;
                    endcase
                end
            end
            default: m = '0;
        endcase
        // no micro-op or a 16-bit encoding
        if (m.micop == MICOP_NONE || i_inst[1:0] != 2'b11) begin
            m = '0;
        end
        m.unknown = (m.micop == MICOP_NONE);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_inst <= i_inst;
            o_match <= m;
        end
    end

    a_unit_vs_unknown: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> ((o_match.unit == UNIT_NONE) == o_match.unknown));

endmodule

/* decoder/uop_encode.sv */
`timescale 1ns/100ps

module uop_encode
    import decode_pkg::*;
(
    input  inst_t     i_inst,
    input  match_t    i_match,
    input  imm20_t    i_imm,
    output dec_info_t o_info
);
    reg_idx_t rd_field;
    reg_idx_t rs1_field;
    reg_idx_t rs2_field;
    logic     rd_wen;
    logic     is_mv;
    logic     is_mem;

    assign rd_field = i_inst[11:7];
    assign rs1_field = i_inst[19:15];
    assign rs2_field = i_inst[24:20];

    // writes to x0 are dropped
    assign rd_wen = i_match.writes_rd && (rd_field != '0);

    // addi rd, rs1, 0 or add rd, rs1, x0
    assign is_mv = i_match.is_mv_candidate &&
                   ((i_match.is_imm_math && (i_imm == '0)) ||
                    (i_match.is_int_math && (rs2_field == '0)));

    assign is_mem = (i_match.unit == UNIT_LDU) || (i_match.unit == UNIT_STU);

    always_comb begin
        o_info.micop = i_match.micop;
        o_info.unit = i_match.unit;
        o_info.imm20 = i_imm;
        o_info.rd_idx = rd_wen ? rd_field : '0;
        o_info.rs1_idx = i_match.reads_rs1 ? rs1_field : '0;
        o_info.rs2_idx = i_match.reads_rs2 ? rs2_field : '0;
        o_info.rd_wen = rd_wen;
        // a move takes its source from rs1 only
        o_info.use_imm = (i_match.imm_fmt != FMT_NONE) && !is_mv;
        o_info.is_mv = is_mv;
        o_info.need_serialize = (i_match.unit == UNIT_SCU);
        o_info.is_store = (i_match.unit == UNIT_STU);
        if (i_match.unknown) begin
            o_info.disp_que = UNKNOWN_BLOCK;
        end else if (is_mem) begin
            o_info.disp_que = MEM_BLOCK;
        end else begin
            o_info.disp_que = INT_BLOCK;
        end
        o_info.issue_que = issue_que_t'(i_match.unit);
    end

endmodule

/* dv/decode_checks.svh */
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s in %s: got %h, expected %h", name, case_name, got, exp);
    end
endtask

// instruction encoders, standard rv formats
function automatic inst_t enc_r(logic [6:0] op, logic [2:0] f3, logic [6:0] f7,
                                reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic inst_t enc_i(logic [6:0] op, logic [2:0] f3, reg_idx_t rd,
                                reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic inst_t enc_s(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic inst_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic inst_t enc_u(logic [6:0] op, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, op};
endfunction

function automatic inst_t enc_j(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic imm20_t sext12(logic [11:0] v);
    return {{8{v[11]}}, v};
endfunction

// regs is {reads rs1, reads rs2, writes rd}
function automatic dec_info_t exp_rec(inst_t inst, exec_unit_t unit, micop_t micop,
                                      imm20_t imm, logic [2:0] regs, logic has_imm, logic mv);
    dec_info_t r;
    reg_idx_t  rd;
    rd = inst[11:7];
    r = '0;
    r.micop = micop;
    r.unit = unit;
    r.imm20 = imm;
    r.rd_wen = regs[0] && (rd != 5'd0);
    r.rd_idx = r.rd_wen ? rd : 5'd0;
    r.rs1_idx = regs[2] ? inst[19:15] : 5'd0;
    r.rs2_idx = regs[1] ? inst[24:20] : 5'd0;
    r.use_imm = has_imm && !mv;
    r.is_mv = mv;
    r.need_serialize = (unit == UNIT_SCU);
    r.is_store = (unit == UNIT_STU);
    r.disp_que = (unit == UNIT_LDU || unit == UNIT_STU) ? MEM_BLOCK : INT_BLOCK;
    r.issue_que = issue_que_t'(unit);
    return r;
endfunction

function automatic dec_info_t unknown_rec();
    dec_info_t r;
    r = '0;
    r.disp_que = UNKNOWN_BLOCK;
    return r;
endfunction

task automatic check_rec(input dec_info_t exp, input logic exp_unk);
    check_val("o_unknown_inst", 32'(o_unknown_inst), 32'(exp_unk));
    check_val("micop", 32'(o_decinfo.micop), 32'(exp.micop));
    check_val("unit", 32'(o_decinfo.unit), 32'(exp.unit));
    check_val("imm20", 32'(o_decinfo.imm20), 32'(exp.imm20));
    check_val("rd_idx", 32'(o_decinfo.rd_idx), 32'(exp.rd_idx));
    check_val("rs1_idx", 32'(o_decinfo.rs1_idx), 32'(exp.rs1_idx));
    check_val("rs2_idx", 32'(o_decinfo.rs2_idx), 32'(exp.rs2_idx));
    check_val("rd_wen", 32'(o_decinfo.rd_wen), 32'(exp.rd_wen));
    check_val("use_imm", 32'(o_decinfo.use_imm), 32'(exp.use_imm));
    check_val("is_mv", 32'(o_decinfo.is_mv), 32'(exp.is_mv));
    check_val("need_serialize", 32'(o_decinfo.need_serialize), 32'(exp.need_serialize));
    check_val("is_store", 32'(o_decinfo.is_store), 32'(exp.is_store));
    check_val("disp_que", 32'(o_decinfo.disp_que), 32'(exp.disp_que));
    check_val("issue_que", 32'(o_decinfo.issue_que), 32'(exp.issue_que));
endtask

// one instruction in, wait for its record
task automatic run_case(input string name, input inst_t inst, input dec_info_t exp,
                        input logic exp_unk);
    int   waited;
    logic seen;
    case_name = name;
    waited = 0;
    seen = 1'b0;
    @(posedge i_clk);
    #2;
    i_valid = 1'b1;
    i_inst = inst;
    while (!seen && waited < 8) begin
        @(posedge i_clk);
        #1;
        seen = o_valid;
        #1;
        i_valid = 1'b0;
        waited++;
    end
    if (!seen) begin
        errors++;
        $display("%s: no valid output within %0d cycles", name, waited);
    end else begin
        check_rec(exp, exp_unk);
    end
endtask

task automatic run_unknown(input string name, input inst_t inst);
    run_case(name, inst, unknown_rec(), 1'b1);
endtask

`endif

/* dv/tb_decode_top.sv */
`timescale 1ns/100ps

module tb_decode_top;
    import decode_pkg::*;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_valid;
    inst_t     i_inst;
    logic      o_valid;
    dec_info_t o_decinfo;
    logic      o_unknown_inst;

    integer seed;
    int     errors;
    int     checks;
    string  case_name;

    decode_top u_dut (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (i_valid),
        .i_inst         (i_inst),
        .o_valid        (o_valid),
        .o_decinfo      (o_decinfo),
        .o_unknown_inst (o_unknown_inst)
    );

    always #10 i_clk = ~i_clk;

    `include "decode_checks.svh"

    task automatic test_alu();
        inst_t i;
        i = enc_r(7'b0110011, 3'b000, 7'b0000000, 5'd5, 5'd6, 5'd7);
        run_case("add", i, exp_rec(i, UNIT_ALU, ALU_ADD, 20'd0, 3'b111, 1'b0, 1'b0), 1'b0);
        // rs2 of x0 makes a move
        i = enc_r(7'b0110011, 3'b000, 7'b0000000, 5'd9, 5'd10, 5'd0);
        run_case("add_mv", i, exp_rec(i, UNIT_ALU, ALU_ADD, 20'd0, 3'b111, 1'b0, 1'b1), 1'b0);
        i = enc_i(7'b0010011, 3'b000, 5'd3, 5'd4, 12'hffb);
        run_case("addi", i, exp_rec(i, UNIT_ALU, ALU_ADD, 20'hffffb, 3'b101, 1'b1, 1'b0), 1'b0);
        i = enc_i(7'b0010011, 3'b000, 5'd3, 5'd4, 12'h000);
        run_case("addi_mv", i, exp_rec(i, UNIT_ALU, ALU_ADD, 20'd0, 3'b101, 1'b1, 1'b1), 1'b0);
        i = enc_r(7'b0111011, 3'b000, 7'b0100000, 5'd8, 5'd9, 5'd10);
        run_case("subw", i, exp_rec(i, UNIT_ALU, ALU_SUBW, 20'd0, 3'b111, 1'b0, 1'b0), 1'b0);
        // shamt 45 needs the sixth bit
        i = enc_i(7'b0010011, 3'b001, 5'd11, 5'd12, {6'd0, 6'd45});
        run_case("slli", i, exp_rec(i, UNIT_ALU, ALU_SLL, 20'd45, 3'b101, 1'b1, 1'b0), 1'b0);
        i = enc_i(7'b0010011, 3'b011, 5'd0, 5'd13, 12'h7ff);
        run_case("sltiu_x0", i, exp_rec(i, UNIT_ALU, ALU_SLTU, 20'h007ff, 3'b101, 1'b1, 1'b0),
                 1'b0);
        i = enc_u(7'b0110111, 5'd14, 20'habcde);
        run_case("lui", i, exp_rec(i, UNIT_ALU, ALU_LUI, 20'habcde, 3'b001, 1'b1, 1'b0), 1'b0);
    endtask

    task automatic test_control();
        inst_t i;
        i = enc_b(3'b000, 5'd1, 5'd2, 13'h1ff0);
        run_case("beq", i, exp_rec(i, UNIT_BRU, BRU_BEQ, 20'hffff0, 3'b110, 1'b1, 1'b0), 1'b0);
        i = enc_b(3'b111, 5'd3, 5'd4, 13'h0ffe);
        run_case("bgeu", i, exp_rec(i, UNIT_BRU, BRU_BGEU, 20'h00ffe, 3'b110, 1'b1, 1'b0), 1'b0);
        // offset bit 20 falls off the 20-bit field
        i = enc_j(5'd1, 21'h1abcde);
        run_case("jal", i, exp_rec(i, UNIT_BRU, BRU_JAL, 20'habcde, 3'b001, 1'b1, 1'b0), 1'b0);
        i = enc_i(7'b1100111, 3'b000, 5'd5, 5'd6, 12'h123);
        run_case("jalr", i, exp_rec(i, UNIT_BRU, BRU_JALR, 20'h00123, 3'b101, 1'b1, 1'b0), 1'b0);
        i = enc_u(7'b0010111, 5'd7, 20'h80001);
        run_case("auipc", i, exp_rec(i, UNIT_BRU, BRU_AUIPC, 20'h80001, 3'b001, 1'b1, 1'b0), 1'b0);
    endtask

    task automatic test_memory();
        inst_t i;
        i = enc_i(7'b0000011, 3'b000, 5'd5, 5'd6, 12'hfff);
        run_case("lb", i, exp_rec(i, UNIT_LDU, LDU_LB, 20'hfffff, 3'b101, 1'b1, 1'b0), 1'b0);
        i = enc_i(7'b0000011, 3'b110, 5'd7, 5'd8, 12'h008);
        run_case("lwu", i, exp_rec(i, UNIT_LDU, LDU_LWU, 20'h00008, 3'b101, 1'b1, 1'b0), 1'b0);
        i = enc_i(7'b0000011, 3'b011, 5'd9, 5'd10, 12'h7f8);
        run_case("ld", i, exp_rec(i, UNIT_LDU, LDU_LD, 20'h007f8, 3'b101, 1'b1, 1'b0), 1'b0);
        i = enc_s(3'b000, 5'd12, 5'd11, 12'hffc);
        run_case("sb", i, exp_rec(i, UNIT_STU, STU_SB, 20'hffffc, 3'b110, 1'b1, 1'b0), 1'b0);
        i = enc_s(3'b011, 5'd14, 5'd13, 12'h3a8);
        run_case("sd", i, exp_rec(i, UNIT_STU, STU_SD, 20'h003a8, 3'b110, 1'b1, 1'b0), 1'b0);
    endtask

    task automatic test_mdu_scu();
        inst_t i;
        i = enc_r(7'b0110011, 3'b010, 7'b0000001, 5'd1, 5'd2, 5'd3);
        run_case("mulhsu", i, exp_rec(i, UNIT_MDU, MDU_MULHSU, 20'd0, 3'b111, 1'b0, 1'b0), 1'b0);
        i = enc_r(7'b0111011, 3'b111, 7'b0000001, 5'd4, 5'd5, 5'd6);
        run_case("remuw", i, exp_rec(i, UNIT_MDU, MDU_REMUW, 20'd0, 3'b111, 1'b0, 1'b0), 1'b0);
        i = enc_i(7'b1110011, 3'b010, 5'd7, 5'd8, 12'h300);
        run_case("csrrs", i, exp_rec(i, UNIT_SCU, SCU_CSRRS, {3'd0, 12'h300, 5'd8}, 3'b101,
                 1'b1, 1'b0), 1'b0);
        // zimm sits in the rs1 field, no register read
        i = enc_i(7'b1110011, 3'b101, 5'd9, 5'd21, 12'h341);
        run_case("csrrwi", i, exp_rec(i, UNIT_SCU, SCU_CSRRWI, {3'd0, 12'h341, 5'd21}, 3'b001,
                 1'b1, 1'b0), 1'b0);
        i = 32'h3020_0073;
        run_case("mret", i, exp_rec(i, UNIT_SCU, SCU_MRET, 20'd0, 3'b000, 1'b0, 1'b0), 1'b0);
        i = 32'h0000_0073;
        run_case("ecall", i, exp_rec(i, UNIT_SCU, SCU_ECALL, 20'd0, 3'b000, 1'b0, 1'b0), 1'b0);
    endtask

    task automatic test_unknown();
        // c.li a0, 0
        run_unknown("compressed", 32'h0000_4501);
        run_unknown("fadd_s", enc_r(7'b1010011, 3'b000, 7'b0000000, 5'd1, 5'd2, 5'd3));
        run_unknown("amoadd_w", enc_r(7'b0101111, 3'b010, 7'b0000000, 5'd5, 5'd6, 5'd7));
        run_unknown("zero_word", 32'h0000_0000);
    endtask

    task automatic test_pipeline();
        inst_t       insts[8];
        dec_info_t   exps[8];
        logic [31:0] rnd;
        logic [11:0] imm;
        int          k;
        case_name = "pipeline";
        for (k = 0; k < 3; k++) begin
            @(posedge i_clk);
            #1;
            check_val("o_valid", 32'(o_valid), 32'd0);
        end
        for (k = 0; k < 8; k++) begin
            rnd = $random(seed);
            imm = rnd[31:20];
            if (k % 2 == 0) begin
                insts[k] = enc_r(7'b0110011, 3'b000, 7'b0000000, rnd[4:0], rnd[9:5], rnd[14:10]);
                exps[k] = exp_rec(insts[k], UNIT_ALU, ALU_ADD, 20'd0, 3'b111, 1'b0,
                                  rnd[14:10] == 5'd0);
            end else begin
                insts[k] = enc_i(7'b0010011, 3'b000, rnd[4:0], rnd[9:5], imm);
                exps[k] = exp_rec(insts[k], UNIT_ALU, ALU_ADD, sext12(imm), 3'b101, 1'b1,
                                  imm == 12'd0);
            end
        end
        // record k must show exactly two edges after its input
        for (k = 0; k < 11; k++) begin
            @(posedge i_clk);
            #1;
            if (k >= 2 && k < 10) begin
                check_val("o_valid", 32'(o_valid), 32'd1);
                check_rec(exps[k - 2], 1'b0);
            end else begin
                check_val("o_valid", 32'(o_valid), 32'd0);
            end
            #1;
            i_valid = (k < 8);
            i_inst = (k < 8) ? insts[k] : '0;
        end
    endtask

    initial begin
        seed = 32'h74475a53;
        errors = 0;
        checks = 0;
        case_name = "reset";
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_inst = '0;
        repeat (2) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #1;
        check_val("o_valid", 32'(o_valid), 32'd0);
        check_val("o_unknown_inst", 32'(o_unknown_inst), 32'd0);
        test_alu();
        test_control();
        test_memory();
        test_mdu_scu();
        test_unknown();
        test_pipeline();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds and runs the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode_top \
    -f sources.f --Mdir obj_dir -o sim_decode > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* source/decode_top.sv */
`timescale 1ns/100ps

module decode_top
    import decode_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_valid,
    input  inst_t     i_inst,
    output logic      o_valid,
    output dec_info_t o_decinfo,
    output logic      o_unknown_inst
);
    logic      s1_valid;
    inst_t     s1_inst;
    match_t    s1_match;
    imm20_t    s1_imm;
    dec_info_t s1_info;

    // stage 1 pattern match
    inst_matcher u_inst_matcher (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_inst  (i_inst),
        .o_valid (s1_valid),
        .o_inst  (s1_inst),
        .o_match (s1_match)
    );

    imm_gen u_imm_gen (
        .i_inst (s1_inst),
        .i_fmt  (s1_match.imm_fmt),
        .o_imm  (s1_imm)
    );

    uop_encode u_uop_encode (
        .i_inst  (s1_inst),
        .i_match (s1_match),
        .i_imm   (s1_imm),
        .o_info  (s1_info)
    );

    // stage 2 output register
    decinfo_reg u_decinfo_reg (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (s1_valid),
        .i_info         (s1_info),
        .i_unknown      (s1_match.unknown),
        .o_valid        (o_valid),
        .o_decinfo      (o_decinfo),
        .o_unknown_inst (o_unknown_inst)
    );

endmodule

/* sources.f */
+incdir+dv
common/decode_pkg.sv
decoder/inst_matcher.sv
decoder/imm_gen.sv
decoder/uop_encode.sv
decoder/decinfo_reg.sv
source/decode_top.sv
dv/tb_decode_top.sv
